// File: hdl/cube_pkg.sv
`default_nettype none

package cube_pkg;

    //////////////////////////////////////////////////
    // sequence sizes
    //////////////////////////////////////////////////

    // bits per move nibble
    localparam int MOVE_BITS = 4;
    // nibbles in one sequence word
    localparam int MAX_MOVES = 50;
    localparam int SEQ_BITS = MOVE_BITS * MAX_MOVES;
    // move count and step index, two hex digits each on the display
    localparam int COUNT_BITS = 8;
    // one stepper motor per face
    localparam int NUM_FACES = 6;

    // bit positions in en_pins
    localparam int RIGHT = 0;
    localparam int UP = 1;
    localparam int FRONT = 2;
    localparam int LEFT = 3;
    localparam int BACK = 4;
    localparam int DOWN = 5;

    //////////////////////////////////////////////////
    // move codes
    //////////////////////////////////////////////////

    // upper three bits are face + 1, low bit set means inverse turn
    localparam logic [MOVE_BITS-1:0] R = 4'd2;
    localparam logic [MOVE_BITS-1:0] Ri = 4'd3;
    localparam logic [MOVE_BITS-1:0] U = 4'd4;
    localparam logic [MOVE_BITS-1:0] Ui = 4'd5;
    localparam logic [MOVE_BITS-1:0] F = 4'd6;
    localparam logic [MOVE_BITS-1:0] Fi = 4'd7;
    localparam logic [MOVE_BITS-1:0] L = 4'd8;
    localparam logic [MOVE_BITS-1:0] Li = 4'd9;
    localparam logic [MOVE_BITS-1:0] B = 4'd10;
    localparam logic [MOVE_BITS-1:0] Bi = 4'd11;
    localparam logic [MOVE_BITS-1:0] D = 4'd12;
    localparam logic [MOVE_BITS-1:0] Di = 4'd13;

    // raw nibble or face field plus inverse flag
    // face field 0 and 7 terminate a sequence
    typedef union packed {
        logic [MOVE_BITS-1:0] raw;
        struct packed {
            logic [MOVE_BITS-2:0] face;
            logic inv;
        } fields;
    } move_code_u;

endpackage

`default_nettype wire

// File: hdl/move_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module move_sequencer (
    input  wire logic                              clk100_mhz,
    input  wire logic                              reset,
    input  wire logic [cube_pkg::SEQ_BITS-1:0]     seq,
    input  wire logic                              seq_valid,
    input  wire logic                              move_done,
    output cube_pkg::move_code_u                   next_move,
    output logic                                   move_start,
    output logic      [cube_pkg::COUNT_BITS-1:0]   num_moves,
    output logic      [cube_pkg::COUNT_BITS-1:0]   curr_step,
    output logic                                   busy,
    output logic                                   done
);

    // fsm encoding
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ISSUE = 2'd1;
    localparam logic [1:0] S_WAIT = 2'd2;
    localparam logic [1:0] S_FINISH = 2'd3;

    logic [1:0] state;

    // latched sequence, one nibble per entry
    logic [cube_pkg::MAX_MOVES-1:0][cube_pkg::MOVE_BITS-1:0] seq_reg;

    // priority scan of the incoming word
    cube_pkg::move_code_u scan_nib;
    logic [cube_pkg::COUNT_BITS-1:0] scan_count;
    logic scan_stop;

    // new sequence only taken when nothing is in flight
    logic accept;

    //////////////////////////////////////////////////
    // count leading valid nibbles
    //////////////////////////////////////////////////

    always_comb begin
        scan_count = '0;
        scan_stop = 1'b0;
        scan_nib = '0;
        for (int k = 0; k < cube_pkg::MAX_MOVES; k++) begin
            scan_nib = seq[k*cube_pkg::MOVE_BITS +: cube_pkg::MOVE_BITS];
            // first face field of 0 or 7 ends the sequence
            if (scan_nib.fields.face == '0 || scan_nib.fields.face == '1) begin
                scan_stop = 1'b1;
            end
            if (!scan_stop) begin
                scan_count = scan_count + 1'b1;
            end
        end
    end

    // busy states ignore the strobe
    assign accept = seq_valid && (state == S_IDLE || state == S_FINISH);

    // payload capture
    always_ff @(posedge clk100_mhz) begin
        if (accept) begin
            seq_reg <= seq;
        end
    end

    //////////////////////////////////////////////////
    // step fsm
    //////////////////////////////////////////////////

    always_ff @(posedge clk100_mhz) begin
        if (reset) begin
            state <= S_IDLE;
            num_moves <= '0;
            curr_step <= '0;
        end else begin
            case (state)
                S_IDLE, S_FINISH: begin
                    if (accept) begin
                        num_moves <= scan_count;
                        curr_step <= '0;
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    // index caught up with count, sequence over
                    if (curr_step == num_moves) begin
                        state <= S_FINISH;
                    end else begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (move_done) begin
                        curr_step <= curr_step + 1'b1;
                        state <= S_ISSUE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign busy = (state == S_ISSUE) || (state == S_WAIT);
    assign done = (state == S_FINISH);

    // one strobe per move, only while moves remain
    assign move_start = (state == S_ISSUE) && (curr_step != num_moves);

    // zero whenever no move is pending
    assign next_move = (busy && curr_step != num_moves) ? seq_reg[curr_step] : '0;

endmodule

`default_nettype wire

// File: hdl/move_to_step.sv
`timescale 1ns/1ps
`default_nettype none

module move_to_step #(
    parameter int STEPS_PER_TURN = 50,
    parameter int STEP_HALF_CYCLES = 2500
) (
    input  wire logic                             clk100_mhz,
    input  wire logic                             reset,
    input  wire cube_pkg::move_code_u             next_move,
    input  wire logic                             move_start,
    output logic                                  move_done,
    output logic                                  dir_pin,
    output logic                                  step_pin,
    output logic      [cube_pkg::NUM_FACES-1:0]   en_pins
);

    // counter widths, wide enough for a count of one
    localparam int HALF_BITS = $clog2(STEP_HALF_CYCLES + 1);
    localparam int STEP_BITS = $clog2(STEPS_PER_TURN + 1);
    localparam logic [HALF_BITS-1:0] HALF_LAST = HALF_BITS'(STEP_HALF_CYCLES - 1);
    localparam logic [STEP_BITS-1:0] STEP_LAST = STEP_BITS'(STEPS_PER_TURN - 1);

    // pulse fsm
    localparam logic [1:0] P_IDLE = 2'd0;
    localparam logic [1:0] P_SETTLE = 2'd1;
    localparam logic [1:0] P_HIGH = 2'd2;
    localparam logic [1:0] P_LOW = 2'd3;

    logic [1:0] state;
    logic [HALF_BITS-1:0] half_cnt;
    logic [STEP_BITS-1:0] step_cnt;

    // one-hot motor select from the face field
    logic [cube_pkg::NUM_FACES-1:0] face_en;

    //////////////////////////////////////////////////
    // face decode
    //////////////////////////////////////////////////

    always_comb begin
        face_en = '0;
        case (next_move.fields.face)
            3'd1: face_en[cube_pkg::RIGHT] = 1'b1;
            3'd2: face_en[cube_pkg::UP] = 1'b1;
            3'd3: face_en[cube_pkg::FRONT] = 1'b1;
            3'd4: face_en[cube_pkg::LEFT] = 1'b1;
            3'd5: face_en[cube_pkg::BACK] = 1'b1;
            3'd6: face_en[cube_pkg::DOWN] = 1'b1;
            // not a move, no motor
            default: face_en = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // pulse train
    //////////////////////////////////////////////////

    always_ff @(posedge clk100_mhz) begin
        if (reset) begin
            state <= P_IDLE;
            half_cnt <= '0;
            step_cnt <= '0;
            move_done <= 1'b0;
            dir_pin <= 1'b0;
            step_pin <= 1'b0;
            en_pins <= '0;
        end else begin
            // done is a single-cycle strobe
            move_done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (move_start) begin
                        en_pins <= face_en;
                        dir_pin <= next_move.fields.inv;
                        half_cnt <= '0;
                        step_cnt <= '0;
                        state <= P_SETTLE;
                    end
                end
                P_SETTLE: begin
                    // driver sees enable and dir one cycle before the first edge
                    step_pin <= 1'b1;
                    state <= P_HIGH;
                end
                P_HIGH: begin
                    if (half_cnt == HALF_LAST) begin
                        half_cnt <= '0;
                        step_pin <= 1'b0;
                        state <= P_LOW;
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                P_LOW: begin
                    if (half_cnt == HALF_LAST) begin
                        half_cnt <= '0;
                        if (step_cnt == STEP_LAST) begin
                            // turn finished, release the motor
                            en_pins <= '0;
                            dir_pin <= 1'b0;
                            move_done <= 1'b1;
                            state <= P_IDLE;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                            step_pin <= 1'b1;
                            state <= P_HIGH;
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/display_8hex.sv
`timescale 1ns/1ps
`default_nettype none

module display_8hex #(
    parameter int SCAN_CYCLES = 100000
) (
    input  wire logic        clk100_mhz,
    input  wire logic        reset,
    input  wire logic [31:0] data,
    output logic      [6:0]  seg,
    output logic      [7:0]  an
);

    localparam int SCAN_BITS = $clog2(SCAN_CYCLES + 1);
    localparam logic [SCAN_BITS-1:0] SCAN_LAST = SCAN_BITS'(SCAN_CYCLES - 1);

    logic [SCAN_BITS-1:0] refresh_cnt;
    // wraps from 7 back to 0 on its own
    logic [2:0] digit_idx;
    logic [3:0] nibble;

    //////////////////////////////////////////////////
    // digit scan
    //////////////////////////////////////////////////

    always_ff @(posedge clk100_mhz) begin
        if (reset) begin
            refresh_cnt <= '0;
            digit_idx <= '0;
        end else if (refresh_cnt == SCAN_LAST) begin
            refresh_cnt <= '0;
            digit_idx <= digit_idx + 1'b1;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // selected digit pulled low
    assign an = ~(8'b0000_0001 << digit_idx);

    assign nibble = data[{digit_idx, 2'b00} +: 4];

    //////////////////////////////////////////////////
    // hex to segments
    //////////////////////////////////////////////////

    // bit order g f e d c b a, low lights the segment
    always_comb begin
        case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'ha: seg = 7'b0001000;
            // lower case b and d
            4'hb: seg = 7'b0000011;
            4'hc: seg = 7'b1000110;
            4'hd: seg = 7'b0100001;
            4'he: seg = 7'b0000110;
            4'hf: seg = 7'b0001110;
            default: seg = 7'b1111111;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/cube_turner.sv
`timescale 1ns/1ps
`default_nettype none

module cube_turner #(
    parameter int STEPS_PER_TURN = 50,
    parameter int STEP_HALF_CYCLES = 2500,
    parameter int SCAN_CYCLES = 100000
) (
    input  wire logic                             clk100_mhz,
    input  wire logic                             reset,
    input  wire logic [cube_pkg::SEQ_BITS-1:0]    seq,
    input  wire logic                             seq_valid,
    output logic                                  busy,
    output logic                                  done,
    output logic                                  dir_pin,
    output logic                                  step_pin,
    output logic      [cube_pkg::NUM_FACES-1:0]   en_pins,
    output logic      [6:0]                       seg,
    output logic      [7:0]                       an
);

    // sequencer to stepper handshake
    cube_pkg::move_code_u next_move;
    logic move_start;
    logic move_done;

    // display counters
    logic [cube_pkg::COUNT_BITS-1:0] num_moves;
    logic [cube_pkg::COUNT_BITS-1:0] curr_step;
    logic [31:0] display_word;

    move_sequencer i_move_sequencer (
        .clk100_mhz (clk100_mhz),
        .reset      (reset),
        .seq        (seq),
        .seq_valid  (seq_valid),
        .move_done  (move_done),
        .next_move  (next_move),
        .move_start (move_start),
        .num_moves  (num_moves),
        .curr_step  (curr_step),
        .busy       (busy),
        .done       (done)
    );

    move_to_step #(
        .STEPS_PER_TURN   (STEPS_PER_TURN),
        .STEP_HALF_CYCLES (STEP_HALF_CYCLES)
    ) i_move_to_step (
        .clk100_mhz (clk100_mhz),
        .reset      (reset),
        .next_move  (next_move),
        .move_start (move_start),
        .move_done  (move_done),
        .dir_pin    (dir_pin),
        .step_pin   (step_pin),
        .en_pins    (en_pins)
    );

    // digits 7..5 blank zero, 4 move, 3..2 step, 1..0 count
    assign display_word = {12'h000, next_move.raw, curr_step, num_moves};

    display_8hex #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) i_display_8hex (
        .clk100_mhz (clk100_mhz),
        .reset      (reset),
        .data       (display_word),
        .seg        (seg),
        .an         (an)
    );

endmodule

`default_nettype wire

// File: testbench/tb_cube_turner_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cube_turner_assertions (
    input wire logic                           clk100_mhz,
    input wire logic                           reset,
    input wire logic                           move_done,
    input wire logic                           step_pin,
    input wire logic [cube_pkg::NUM_FACES-1:0] en_pins
);

    // only one motor powered at a time
    property en_pins_onehot0;
        @(posedge clk100_mhz) disable iff (reset)
        $onehot0(en_pins);
    endproperty

    // no step edge to an unpowered driver
    property step_needs_enable;
        @(posedge clk100_mhz) disable iff (reset)
        step_pin |-> (en_pins != '0);
    endproperty

    // done strobe never stretches
    property move_done_single;
        @(posedge clk100_mhz) disable iff (reset)
        move_done |=> !move_done;
    endproperty

    a_en_pins_onehot0: assert property (en_pins_onehot0)
        else $error("more than one motor enabled, en_pins %h", en_pins);
    a_step_needs_enable: assert property (step_needs_enable)
        else $error("step_pin high with no motor enabled");
    a_move_done_single: assert property (move_done_single)
        else $error("move_done held for more than one cycle");

endmodule

bind move_to_step tb_cube_turner_assertions i_assertions (
    .clk100_mhz (clk100_mhz),
    .reset      (reset),
    .move_done  (move_done),
    .step_pin   (step_pin),
    .en_pins    (en_pins)
);

`default_nettype wire

// File: testbench/tb_cube_turner.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cube_turner;

    // short rates for simulation
    localparam int STEPS_PER_TURN = 3;
    localparam int STEP_HALF_CYCLES = 2;
    localparam int SCAN_CYCLES = 4;
    localparam int NUM_ENTRIES = 10;
    // upper bound on cycles for one move including the handshake
    localparam int MOVE_CYCLES = 2 * STEP_HALF_CYCLES * STEPS_PER_TURN + 4;

    logic clk100_mhz = 1'b0;
    logic reset;
    logic [cube_pkg::SEQ_BITS-1:0] seq;
    logic seq_valid;
    logic busy;
    logic done;
    logic dir_pin;
    logic step_pin;
    logic [cube_pkg::NUM_FACES-1:0] en_pins;
    logic [6:0] seg;
    logic [7:0] an;

    // stimulus table and expected move counts
    logic [cube_pkg::SEQ_BITS-1:0] table_seq [NUM_ENTRIES];
    int table_count [NUM_ENTRIES];
    // gfedcba order with low lighting a segment
    logic [6:0] seg_table [16];

    logic [31:0] rng_state;
    int cycle_count = 0;
    int cycle_limit;

    // one entry per turned move
    int obs_face [$];
    bit obs_dir [$];
    int obs_pulses [$];
    int total_pulses;
    logic step_prev;
    logic [cube_pkg::NUM_FACES-1:0] en_prev;
    int cur_face;
    bit cur_dir;
    int cur_pulses;

    cube_turner #(
        .STEPS_PER_TURN   (STEPS_PER_TURN),
        .STEP_HALF_CYCLES (STEP_HALF_CYCLES),
        .SCAN_CYCLES      (SCAN_CYCLES)
    ) i_cube_turner (
        .clk100_mhz (clk100_mhz),
        .reset      (reset),
        .seq        (seq),
        .seq_valid  (seq_valid),
        .busy       (busy),
        .done       (done),
        .dir_pin    (dir_pin),
        .step_pin   (step_pin),
        .en_pins    (en_pins),
        .seg        (seg),
        .an         (an)
    );

    always #5 clk100_mhz = ~clk100_mhz;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic halt_with_failure;
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            halt_with_failure();
        end
    endtask

    // lcg with the numerical recipes constants
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // highest set bit or -1 if none
    function automatic int bit_index(input logic [7:0] bits);
        int idx;
        idx = -1;
        for (int i = 0; i < 8; i++) begin
            if (bits[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////
    // watchdog and pulse monitor
    //////////////////////////////////////////////////

    always @(posedge clk100_mhz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            halt_with_failure();
        end
    end

    // outputs settle after posedge so sample on the falling edge
    always @(negedge clk100_mhz) begin
        if (reset) begin
            step_prev = 1'b0;
            en_prev = '0;
        end else begin
            // enable rising opens a move
            if (en_pins != '0 && en_prev == '0) begin
                cur_face = bit_index(8'(en_pins));
                cur_dir = dir_pin;
                cur_pulses = 0;
            end
            if (step_pin && !step_prev) begin
                total_pulses = total_pulses + 1;
                cur_pulses = cur_pulses + 1;
                assert (en_pins != '0) else begin
                    $display("step pulse seen while no motor was enabled");
                    halt_with_failure();
                end
                check_value("dir_pin", 32'(dir_pin), 32'(cur_dir));
            end
            // enable falling closes it
            if (en_pins == '0 && en_prev != '0) begin
                obs_face.push_back(cur_face);
                obs_dir.push_back(cur_dir);
                obs_pulses.push_back(cur_pulses);
            end
            step_prev = step_pin;
            en_prev = en_pins;
        end
    end

    //////////////////////////////////////////////////
    // one table entry
    //////////////////////////////////////////////////

    task automatic run_entry(input int entry);
        logic [cube_pkg::SEQ_BITS-1:0] word;
        logic [3:0] nib;
        logic [31:0] exp_word;
        logic [7:0] seen;
        int exp_count;
        int exp_face;
        int digit;
        word = table_seq[entry];
        exp_count = table_count[entry];
        obs_face.delete();
        obs_dir.delete();
        obs_pulses.delete();
        total_pulses = 0;
        seq = word;
        seq_valid = 1'b1;
        @(negedge clk100_mhz);
        seq_valid = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
        check_value("done", 32'(done), 32'd0);
        if (exp_count > 0) begin
            // stray strobe while busy that must be dropped
            seq = {cube_pkg::MAX_MOVES{4'hd}};
            seq_valid = 1'b1;
            @(negedge clk100_mhz);
            seq_valid = 1'b0;
        end else begin
            @(negedge clk100_mhz);
            check_value("done", 32'(done), 32'd1);
        end
        while (done !== 1'b1) begin
            @(negedge clk100_mhz);
        end
        check_value("busy", 32'(busy), 32'd0);
        check_value("en_pins", 32'(en_pins), 32'd0);
        check_value("step_pin", 32'(step_pin), 32'd0);
        check_value("moves turned", obs_face.size(), exp_count);
        check_value("step_pin total", total_pulses, exp_count * STEPS_PER_TURN);
        // moves in order from the low nibble
        for (int k = 0; k < exp_count; k++) begin
            nib = word[k*cube_pkg::MOVE_BITS +: cube_pkg::MOVE_BITS];
            exp_face = int'(nib[3:1]) - 1;
            check_value("en_pins face", obs_face[k], exp_face);
            check_value("dir_pin", 32'(obs_dir[k]), 32'(nib[0]));
            check_value("step_pin count", obs_pulses[k], STEPS_PER_TURN);
        end
        // move digit reads zero once idle
        exp_word = {16'h0000, 8'(exp_count), 8'(exp_count)};
        seen = '0;
        repeat (8 * SCAN_CYCLES) begin
            check_value("an low count", $countones(~an), 1);
            digit = bit_index(~an);
            seen[digit] = 1'b1;
            check_value("seg", 32'(seg), 32'(seg_table[exp_word[digit*4 +: 4]]));
            @(negedge clk100_mhz);
        end
        check_value("an digits seen", 32'(seen), 32'hff);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int total_moves;
        int len;
        logic [31:0] r;
        reset = 1'b1;
        seq = '0;
        seq_valid = 1'b0;
        rng_state = 32'h240c;
        total_pulses = 0;
        seg_table[0] = 7'b1000000;
        seg_table[1] = 7'b1111001;
        seg_table[2] = 7'b0100100;
        seg_table[3] = 7'b0110000;
        seg_table[4] = 7'b0011001;
        seg_table[5] = 7'b0010010;
        seg_table[6] = 7'b0000010;
        seg_table[7] = 7'b1111000;
        seg_table[8] = 7'b0000000;
        seg_table[9] = 7'b0010000;
        seg_table[10] = 7'b0001000;
        seg_table[11] = 7'b0000011;
        seg_table[12] = 7'b1000110;
        seg_table[13] = 7'b0100001;
        seg_table[14] = 7'b0000110;
        seg_table[15] = 7'b0001110;
        // Ri alone then R Ri
        table_seq[0] = cube_pkg::SEQ_BITS'(cube_pkg::Ri);
        table_count[0] = 1;
        table_seq[1] = cube_pkg::SEQ_BITS'({cube_pkg::Ri, cube_pkg::R});
        table_count[1] = 2;
        // every code 2 to 13
        table_seq[2] = cube_pkg::SEQ_BITS'(48'hdcba98765432);
        table_count[2] = 12;
        // zero nibble after three moves with junk beyond
        table_seq[3] = cube_pkg::SEQ_BITS'(24'h650ca4);
        table_count[3] = 3;
        // face field 0 in nibble 0
        table_seq[4] = cube_pkg::SEQ_BITS'(8'h41);
        table_count[4] = 0;
        table_seq[5] = '0;
        for (int k = 0; k < cube_pkg::MAX_MOVES; k++) begin
            table_seq[5][k*4 +: 4] = 4'(2 + k % 12);
        end
        table_count[5] = cube_pkg::MAX_MOVES;
        for (int e = 6; e < NUM_ENTRIES; e++) begin
            len = 1 + int'((next_random() >> 16) % 24);
            for (int k = 0; k < cube_pkg::MAX_MOVES; k++) begin
                r = next_random() >> 16;
                table_seq[e][k*4 +: 4] = 4'(2 + r % 12);
            end
            // end marker picked from 0, 1, 14, 15
            r = (next_random() >> 16) & 32'd3;
            table_seq[e][len*4 +: 4] = (r < 2) ? 4'(r) : 4'(r + 12);
            table_count[e] = len;
        end
        total_moves = 0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            total_moves = total_moves + table_count[e];
        end
        cycle_limit = 8 + total_moves * MOVE_CYCLES + NUM_ENTRIES * (20 + 16 * SCAN_CYCLES);
        repeat (8) @(negedge clk100_mhz);
        reset = 1'b0;
        @(negedge clk100_mhz);
        // idle outputs after reset
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("step_pin", 32'(step_pin), 32'd0);
        check_value("en_pins", 32'(en_pins), 32'd0);
        check_value("dir_pin", 32'(dir_pin), 32'd0);
        check_value("an", 32'(an), 32'hfe);
        check_value("seg", 32'(seg), 32'(seg_table[0]));
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/cube_pkg.sv
hdl/move_sequencer.sv
hdl/move_to_step.sv
hdl/display_8hex.sv
hdl/cube_turner.sv
testbench/tb_cube_turner_assertions.sv
testbench/tb_cube_turner.sv

// File: Makefile
# Verilator flow for the cube turner testbench

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module tb_cube_turner -f verilog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cube_turner \
	    -f verilog.f -Mdir obj_dir -o sim_cube_turner
	./obj_dir/sim_cube_turner 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
	    echo "simulation reported a failure"; \
	    exit 1; \
	fi
	@grep -q "Verification passed" $(LOG) || \
	    (echo "simulation ended without a pass line"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
